// File: Makefile
# Verilator build and run of the peripheral subsystem testbench

TOP := periph_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --top-module $(TOP) -f flist.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -qx "TEST RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
+incdir+logic
logic/periph_pkg.sv
logic/wb_decode.sv
logic/gpio_bank.sv
logic/debounce.sv
logic/periph_top.sv
tb/periph_tb.sv

// File: logic/debounce.sv
`timescale 1ns/1ns
`include "periph_config.svh"

// debouncer for the push buttons and slide switches
// each bit runs a two flop synchroniser followed by a stability counter
module debounce (
   input  logic                clk,
   input  logic                i_arst_n,
   input  periph_pkg::button_t i_buttons,
   input  periph_pkg::switch_t i_switches,
   output periph_pkg::button_t o_buttons,
   output periph_pkg::switch_t o_switches
);

   import periph_pkg::*;

   localparam int BTN_W  = $bits(button_t);
   localparam int NUM_IN = BTN_W + $bits(switch_t);
   localparam int CNT_W  = $clog2(`DB_CYCLES + 1);
   // the flip happens on the edge that would make this the DB_CYCLES count
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DB_CYCLES - 1);

   logic [NUM_IN-1:0] raw;
   logic [NUM_IN-1:0] sync1_q;
   logic [NUM_IN-1:0] sync2_q;
   logic [NUM_IN-1:0] db_q;
   logic [CNT_W-1:0]  cnt_q [NUM_IN];

   // buttons in the low bits, switches above them
   assign raw = {i_switches, i_buttons};

   // ************************************************************
   // synchroniser
   // ************************************************************

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= raw;
         sync2_q <= sync1_q;
      end
   end

   // ************************************************************
   // stability counters
   // ************************************************************

   // a bit that matches its debounced value keeps its counter at zero
   // any bounce back therefore restarts the count, and a pulse shorter
   // than DB_CYCLES samples never reaches the output
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         db_q <= '0;
         for (int i = 0; i < NUM_IN; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_IN; i++) begin
            if (sync2_q[i] == db_q[i]) begin
               cnt_q[i] <= '0;
            end else if (cnt_q[i] == CNT_LAST) begin
               db_q[i]  <= sync2_q[i];
               cnt_q[i] <= '0;
            end else begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign o_buttons  = button_t'(db_q[BTN_W-1:0]);
   assign o_switches = switch_t'(db_q[NUM_IN-1:BTN_W]);

endmodule

// File: logic/gpio_bank.sv
`timescale 1ns/1ns
`include "periph_config.svh"

// one gpio bank with input, output and output enable registers
// pin_t sets the payload width, reads zero extend it to the bus width
module gpio_bank #(
   parameter type pin_t = periph_pkg::gpio_word_t
) (
   input  logic                clk,
   input  logic                i_arst_n,
   input  periph_pkg::wb_req_t i_req,
   output periph_pkg::wb_rsp_t o_rsp,
   input  pin_t                i_pins,
   output pin_t                o_pins,
   output pin_t                o_pins_oe
);

   localparam int PIN_W = $bits(pin_t);

   logic [`BANK_OFS_W-1:0]    ofs;
   logic                      req_new;
   logic                      hit_in;
   logic                      hit_out;
   logic                      hit_oe;
   logic                      ack_q;
   // which register the pending read returns, all zero for writes and holes
   logic                      rd_in_q;
   logic                      rd_out_q;
   logic                      rd_oe_q;
   pin_t                      in_q;
   pin_t                      out_q;
   pin_t                      oe_q;
   logic [`PERIPH_DATA_W-1:0] rd_word;

   // ************************************************************
   // request decode
   // ************************************************************

   // stb stays high during the ack cycle, ack_q keeps it from counting twice
   assign req_new = i_req.cyc & i_req.stb & ~ack_q;
   assign ofs     = i_req.adr[`BANK_OFS_W-1:0];
   assign hit_in  = (ofs == `REG_IN_OFS);
   assign hit_out = (ofs == `REG_OUT_OFS);
   assign hit_oe  = (ofs == `REG_OE_OFS);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         ack_q    <= 1'b0;
         rd_in_q  <= 1'b0;
         rd_out_q <= 1'b0;
         rd_oe_q  <= 1'b0;
         out_q    <= '0;
         oe_q     <= '0;
      end else begin
         ack_q    <= req_new;
         rd_in_q  <= req_new & ~i_req.we & hit_in;
         rd_out_q <= req_new & ~i_req.we & hit_out;
         rd_oe_q  <= req_new & ~i_req.we & hit_oe;
         // the in register is read only, writes to it are dropped
         if (req_new & i_req.we & hit_out) begin
            out_q <= pin_t'(i_req.dat[PIN_W-1:0]);
         end
         if (req_new & i_req.we & hit_oe) begin
            oe_q <= pin_t'(i_req.dat[PIN_W-1:0]);
         end
      end
   end

   // pins are sampled on every edge, so a read sees them one cycle before ack
   always_ff @(posedge clk) begin
      in_q <= i_pins;
   end

   // ************************************************************
   // read data and outputs
   // ************************************************************

   always_comb begin
      rd_word = '0;
      if (rd_in_q) begin
         rd_word[PIN_W-1:0] = in_q;
      end else if (rd_out_q) begin
         rd_word[PIN_W-1:0] = out_q;
      end else if (rd_oe_q) begin
         rd_word[PIN_W-1:0] = oe_q;
      end
   end

   assign o_rsp.ack = ack_q;
   assign o_rsp.dat = rd_word;
   assign o_pins    = out_q;
   assign o_pins_oe = oe_q;

   // a single access never gets a second ack, even with stb still high
   ack_single_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      ack_q |=> !ack_q);

endmodule

// File: logic/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// ************************************************************
// bus geometry
// ************************************************************

// byte address width seen by the peripheral subsystem
`define PERIPH_ADDR_W     8
`define PERIPH_DATA_W     32

// board pins, slide switches and the robot control byte
`define PERIPH_GPIO_W     32
`define PERIPH_NUM_SW     16
`define BOT_CTRL_W        8
// the debounced switch that doubles as the robot configuration level
`define BOT_CONFIG_SW     15

// ************************************************************
// bank map
// ************************************************************

// address bits 7:6 pick the bank, so each bank spans 64 bytes
`define BANK_OFS_W        6
`define PERIPH_NUM_BANKS  3
`define BANK_IDX_BOARD    0
`define BANK_IDX_BUTTON   1
`define BANK_IDX_ROBOT    2
`define BANK_BOARD_BASE   8'h00
`define BANK_BUTTON_BASE  8'h40
`define BANK_ROBOT_BASE   8'h80

// registers inside a bank, anything else reads zero
`define REG_IN_OFS        6'h00
`define REG_OUT_OFS       6'h04
`define REG_OE_OFS        6'h08

// stable synchronised samples needed before a debounced bit flips
`define DB_CYCLES         8

`endif

// File: logic/periph_pkg.sv
`include "periph_config.svh"

package periph_pkg;

   // ************************************************************
   // wishbone transport
   // ************************************************************

   // one request from the master, held until the matching ack
   // the address is a byte address but always word aligned (bits 1:0 zero)
   typedef struct packed {
      logic                      cyc;
      logic                      stb;
      logic                      we;
      logic [`PERIPH_ADDR_W-1:0] adr;
      logic [`PERIPH_DATA_W-1:0] dat;
   } wb_req_t;

   // read data is only meaningful while ack is high
   typedef struct packed {
      logic                      ack;
      logic [`PERIPH_DATA_W-1:0] dat;
   } wb_rsp_t;

   // ************************************************************
   // pin payloads
   // ************************************************************

   // a full 32 pin word, used by the board bank and the robot bank
   typedef logic [`PERIPH_GPIO_W-1:0] gpio_word_t;

   // the last member lands in bit 0, so up is bit 0 and center is bit 4
   typedef struct packed {
      logic center;
      logic right;
      logic left;
      logic down;
      logic up;
   } button_t;

   typedef logic [`PERIPH_NUM_SW-1:0] switch_t;

   // one-hot bank choice, all zero means the address is unmapped
   typedef struct packed {
      logic robot;
      logic button;
      logic board;
   } bank_sel_t;

endpackage

// File: logic/periph_top.sv
`timescale 1ns/1ns
`include "periph_config.svh"

// wishbone peripheral subsystem for the robot controller
// the board adds the pad buffers, so every pin comes as separate in, out and enable
module periph_top (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  periph_pkg::wb_req_t    i_wb,
   output periph_pkg::wb_rsp_t    o_wb,
   input  periph_pkg::gpio_word_t i_gpio,
   output periph_pkg::gpio_word_t o_gpio,
   output periph_pkg::gpio_word_t o_gpio_oe,
   input  periph_pkg::button_t    i_buttons,
   input  periph_pkg::switch_t    i_switches,
   input  periph_pkg::gpio_word_t i_bot_info,
   output logic [`BOT_CTRL_W-1:0] o_bot_ctrl,
   output logic                   o_bot_config
);

   import periph_pkg::*;

   // per bank request and response, indexed by the BANK_IDX macros
   wb_req_t    bank_req [`PERIPH_NUM_BANKS];
   wb_rsp_t    bank_rsp [`PERIPH_NUM_BANKS];

   button_t    db_buttons;
   switch_t    db_switches;
   // full robot output word, only the low byte leaves the chip
   gpio_word_t robot_out;

   // ************************************************************
   // bus fabric
   // ************************************************************

   wb_decode wb_decode_inst (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_wb       (i_wb),
      .o_wb       (o_wb),
      .o_bank_req (bank_req),
      .i_bank_rsp (bank_rsp)
   );

   // ************************************************************
   // input filtering
   // ************************************************************

   debounce debounce_inst (
      .clk        (clk),
      .i_arst_n   (i_arst_n),
      .i_buttons  (i_buttons),
      .i_switches (i_switches),
      .o_buttons  (db_buttons),
      .o_switches (db_switches)
   );

   // switch 15 selects the robot configuration
   assign o_bot_config = db_switches[`BOT_CONFIG_SW];

   // ************************************************************
   // gpio banks
   // ************************************************************

   // board pins with per pin output enables
   gpio_bank #(.pin_t(gpio_word_t)) board_bank (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_req     (bank_req[`BANK_IDX_BOARD]),
      .o_rsp     (bank_rsp[`BANK_IDX_BOARD]),
      .i_pins    (i_gpio),
      .o_pins    (o_gpio),
      .o_pins_oe (o_gpio_oe)
   );

   // push buttons are input only, the bank's output registers stay open
   gpio_bank #(.pin_t(button_t)) button_bank (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_req     (bank_req[`BANK_IDX_BUTTON]),
      .o_rsp     (bank_rsp[`BANK_IDX_BUTTON]),
      .i_pins    (db_buttons),
      .o_pins    (),
      .o_pins_oe ()
   );

   // robot status comes in as a word, control goes out as a byte
   gpio_bank #(.pin_t(gpio_word_t)) robot_bank (
      .clk       (clk),
      .i_arst_n  (i_arst_n),
      .i_req     (bank_req[`BANK_IDX_ROBOT]),
      .o_rsp     (bank_rsp[`BANK_IDX_ROBOT]),
      .i_pins    (i_bot_info),
      .o_pins    (robot_out),
      .o_pins_oe ()
   );

   assign o_bot_ctrl = robot_out[`BOT_CTRL_W-1:0];

endmodule

// File: logic/wb_decode.sv
`timescale 1ns/1ns
`include "periph_config.svh"

// splits the master's bus into one request per bank and merges the responses
module wb_decode (
   input  logic                clk,
   input  logic                i_arst_n,
   input  periph_pkg::wb_req_t i_wb,
   output periph_pkg::wb_rsp_t o_wb,
   output periph_pkg::wb_req_t o_bank_req [`PERIPH_NUM_BANKS],
   input  periph_pkg::wb_rsp_t i_bank_rsp [`PERIPH_NUM_BANKS]
);

   import periph_pkg::*;

   logic                         req_valid;
   logic [`PERIPH_ADDR_W-1:0]    bank_base;
   bank_sel_t                    bank_sel;
   logic [`PERIPH_NUM_BANKS-1:0] sel_vec;
   // bank that owns the access now being acknowledged
   logic [`PERIPH_NUM_BANKS-1:0] rsp_sel_q;
   logic                         unmapped_ack_q;

   assign req_valid = i_wb.cyc & i_wb.stb;

   // ************************************************************
   // address decode
   // ************************************************************

   // clear the offset bits so the address compares directly with the bases
   assign bank_base = {i_wb.adr[`PERIPH_ADDR_W-1:`BANK_OFS_W], {`BANK_OFS_W{1'b0}}};

   always_comb begin
      bank_sel = '0;
      case (bank_base)
         `BANK_BOARD_BASE:  bank_sel.board  = 1'b1;
         `BANK_BUTTON_BASE: bank_sel.button = 1'b1;
         `BANK_ROBOT_BASE:  bank_sel.robot  = 1'b1;
         // the top quarter of the map has no bank
         default:           bank_sel = '0;
      endcase
   end

   always_comb begin
      sel_vec                  = '0;
      sel_vec[`BANK_IDX_BOARD]  = bank_sel.board;
      sel_vec[`BANK_IDX_BUTTON] = bank_sel.button;
      sel_vec[`BANK_IDX_ROBOT]  = bank_sel.robot;
   end

   // every bank sees the whole request but only the chosen one gets stb
   always_comb begin
      for (int i = 0; i < `PERIPH_NUM_BANKS; i++) begin
         o_bank_req[i]     = i_wb;
         o_bank_req[i].stb = i_wb.stb & sel_vec[i];
      end
   end

   // ************************************************************
   // response path
   // ************************************************************

   // the master holds the address through the ack cycle, so sampling the
   // selection while stb is high keeps it valid when the ack comes back
   // an unmapped access gets its own one cycle ack with zero data
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rsp_sel_q      <= '0;
         unmapped_ack_q <= 1'b0;
      end else begin
         rsp_sel_q      <= req_valid ? sel_vec : '0;
         unmapped_ack_q <= req_valid & (sel_vec == '0) & ~unmapped_ack_q;
      end
   end

   always_comb begin
      o_wb     = '0;
      o_wb.ack = unmapped_ack_q;
      for (int i = 0; i < `PERIPH_NUM_BANKS; i++) begin
         if (rsp_sel_q[i]) begin
            o_wb = i_bank_rsp[i];
         end
      end
   end

   // at most one bank or the unmapped path answers on any given edge
   sel_onehot_a: assert property (@(posedge clk) disable iff (!i_arst_n)
      $onehot0({i_bank_rsp[`BANK_IDX_ROBOT].ack, i_bank_rsp[`BANK_IDX_BUTTON].ack,
                i_bank_rsp[`BANK_IDX_BOARD].ack, unmapped_ack_q}));

endmodule

// File: tb/periph_tb.sv
`timescale 1ns/1ns
`include "periph_config.svh"

module periph_tb;

   import periph_pkg::*;

   // ************************************************************
   // test sizes and run limit
   // ************************************************************

   localparam int N_BOARD  = 20;
   localparam int N_ROBOT  = 16;
   localparam int N_DB     = 12;
   localparam int N_UNMAP  = 16;
   localparam int N_RAND   = 48;
   // one access takes three cycles, the last one idle after the ack
   localparam int ACC      = 3;
   localparam int SETTLE   = `DB_CYCLES + 4;
   localparam int ACK_WAIT = 4;
   localparam int EST_CYCLES = 12 + 6 * ACC + N_BOARD * (5 * ACC + 2)
      + N_ROBOT * (3 * ACC + 2) + N_DB * (2 * `DB_CYCLES + 2 * SETTLE + 2 * ACC + 2)
      + N_UNMAP * 4 * ACC + N_RAND * ACC;
   localparam int TIMEOUT  = 2 * EST_CYCLES;

   // buttons sit in the low bits of the debounce model, switches above
   localparam int BTN_W   = $bits(button_t);
   localparam int NUM_DB  = BTN_W + $bits(switch_t);
   localparam int CFG_BIT = BTN_W + `BOT_CONFIG_SW;

   logic                   clk;
   logic                   i_arst_n;
   wb_req_t                i_wb;
   wb_rsp_t                o_wb;
   gpio_word_t             i_gpio;
   gpio_word_t             o_gpio;
   gpio_word_t             o_gpio_oe;
   button_t                i_buttons;
   switch_t                i_switches;
   gpio_word_t             i_bot_info;
   logic [`BOT_CTRL_W-1:0] o_bot_ctrl;
   logic                   o_bot_config;

   // expected out and enable registers, one entry per bank
   gpio_word_t        exp_out [3];
   gpio_word_t        exp_oe [3];
   // debounce model, committed level and the two edges until it shows
   logic [NUM_DB-1:0] db_target;
   logic [NUM_DB-1:0] db_d1;
   logic [NUM_DB-1:0] db_d2;
   logic [NUM_DB-1:0] db_vis;
   logic [NUM_DB-1:0] db_vis_prev;
   int                db_run [NUM_DB];

   logic [15:0] lfsr_q;
   int          checks;
   int          value_errs;
   int          bus_errs;
   int          cycle_cnt = 0;

   periph_top periph_top_inst (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_wb         (i_wb),
      .o_wb         (o_wb),
      .i_gpio       (i_gpio),
      .o_gpio       (o_gpio),
      .o_gpio_oe    (o_gpio_oe),
      .i_buttons    (i_buttons),
      .i_switches   (i_switches),
      .i_bot_info   (i_bot_info),
      .o_bot_ctrl   (o_bot_ctrl),
      .o_bot_config (o_bot_config)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // ************************************************************
   // reference model
   // ************************************************************

   // a raw level that differs from the committed one for DB_CYCLES
   // consecutive samples is committed, and it shows two edges later
   always @(posedge clk) begin
      logic [NUM_DB-1:0] raw;
      raw = {i_switches, i_buttons};
      if (!i_arst_n) begin
         db_target   = '0;
         db_d1       = '0;
         db_d2       = '0;
         db_vis      = '0;
         db_vis_prev = '0;
         for (int i = 0; i < NUM_DB; i++) begin
            db_run[i] = 0;
         end
      end else begin
         // the button in register holds the level from before this edge
         db_vis_prev = db_vis;
         db_vis      = db_d2;
         db_d2       = db_d1;
         for (int i = 0; i < NUM_DB; i++) begin
            if (raw[i] == db_target[i]) begin
               db_run[i] = 0;
            end else begin
               db_run[i]++;
               if (db_run[i] == `DB_CYCLES) begin
                  db_target[i] = raw[i];
                  db_run[i]    = 0;
               end
            end
         end
         db_d1 = db_target;
      end
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
         print_counts();
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // 16 bit fibonacci LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic logic [`PERIPH_ADDR_W-1:0] reg_addr(input int bank, input logic [5:0] ofs);
      logic [`PERIPH_ADDR_W-1:0] base;
      case (bank)
         0:       base = `BANK_BOARD_BASE;
         1:       base = `BANK_BUTTON_BASE;
         default: base = `BANK_ROBOT_BASE;
      endcase
      return base | {2'b00, ofs};
   endfunction

   // read value from the map, unmapped banks and holes read zero
   function automatic gpio_word_t expected_read(input logic [`PERIPH_ADDR_W-1:0] adr);
      logic [1:0] bank;
      logic [5:0] ofs;
      gpio_word_t word;
      bank = adr[7:6];
      ofs  = adr[5:0];
      word = '0;
      if (bank != 2'd3) begin
         if (ofs == `REG_IN_OFS) begin
            case (bank)
               2'd0:    word = i_gpio;
               2'd1:    word = gpio_word_t'(db_vis_prev[BTN_W-1:0]);
               default: word = i_bot_info;
            endcase
         end else if (ofs == `REG_OUT_OFS) begin
            word = exp_out[bank];
         end else if (ofs == `REG_OE_OFS) begin
            word = exp_oe[bank];
         end
      end
      return word;
   endfunction

   task automatic model_write(input logic [`PERIPH_ADDR_W-1:0] adr, input gpio_word_t dat);
      int         bank;
      logic [5:0] ofs;
      gpio_word_t mask;
      bank = int'(adr[7:6]);
      ofs  = adr[5:0];
      mask = '1;
      // the button bank only keeps one bit per button
      if (bank == 1) begin
         mask = mask >> (32 - BTN_W);
      end
      if (bank < 3) begin
         if (ofs == `REG_OUT_OFS) begin
            exp_out[bank] = dat & mask;
         end else if (ofs == `REG_OE_OFS) begin
            exp_oe[bank] = dat & mask;
         end
      end
   endtask

   // ************************************************************
   // compare tasks
   // ************************************************************

   task automatic compare_rsp(input string name, input wb_rsp_t expected, input wb_rsp_t actual);
      checks++;
      if (actual !== expected) begin
         value_errs++;
         $display("ERROR %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic compare_word(input string name, input gpio_word_t expected,
                               input gpio_word_t actual);
      checks++;
      if (actual !== expected) begin
         value_errs++;
         $display("ERROR %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic compare_button(input string name, input button_t expected,
                                 input button_t actual);
      checks++;
      if (actual !== expected) begin
         value_errs++;
         $display("ERROR %s: expected %h, got %h", name, expected, actual);
      end
   endtask

   task automatic print_counts();
      $display("checks %0d, value errors %0d, bus errors %0d", checks, value_errs, bus_errs);
   endtask

   task automatic check_outputs();
      compare_word("o_gpio", exp_out[0], o_gpio);
      compare_word("o_gpio_oe", exp_oe[0], o_gpio_oe);
      compare_word("o_bot_ctrl", gpio_word_t'(exp_out[2][`BOT_CTRL_W-1:0]),
                   gpio_word_t'(o_bot_ctrl));
   endtask

   // o_bot_config is compared with the model on every falling edge
   task automatic watch_config();
      forever begin
         @(negedge clk);
         compare_word("o_bot_config", gpio_word_t'(db_vis[CFG_BIT]), gpio_word_t'(o_bot_config));
      end
   endtask

   // ************************************************************
   // wishbone master
   // ************************************************************

   // ack must come on the first edge that sees stb and last one cycle
   task automatic bus_access(input logic we, input logic [`PERIPH_ADDR_W-1:0] adr,
                             input logic [`PERIPH_DATA_W-1:0] dat, output wb_rsp_t rsp,
                             output gpio_word_t exp_rd);
      int waited;
      @(posedge clk);
      #1;
      i_wb.cyc = 1'b1;
      i_wb.stb = 1'b1;
      i_wb.we  = we;
      i_wb.adr = adr;
      i_wb.dat = dat;
      @(negedge clk);
      if (o_wb.ack) begin
         $display("ack for address %h rose before the request was sampled", adr);
         bus_errs++;
      end
      @(negedge clk);
      waited = 0;
      while (!o_wb.ack && waited < ACK_WAIT) begin
         @(negedge clk);
         waited++;
      end
      if (!o_wb.ack) begin
         $display("no ack for the access at address %h", adr);
         bus_errs++;
      end else if (waited != 0) begin
         $display("ack for address %h came %0d cycles late", adr, waited);
         bus_errs++;
      end
      rsp    = o_wb;
      exp_rd = expected_read(adr);
      @(posedge clk);
      #1;
      i_wb = '0;
      @(negedge clk);
      if (o_wb.ack) begin
         $display("ack for address %h stayed high for a second cycle", adr);
         bus_errs++;
      end
   endtask

   task automatic do_write(input logic [`PERIPH_ADDR_W-1:0] adr, input gpio_word_t dat);
      wb_rsp_t    rsp;
      gpio_word_t unused_rd;
      bus_access(1'b1, adr, dat, rsp, unused_rd);
      model_write(adr, dat);
      check_outputs();
   endtask

   task automatic do_read(input logic [`PERIPH_ADDR_W-1:0] adr, output wb_rsp_t rsp);
      gpio_word_t exp_rd;
      wb_rsp_t    expected;
      bus_access(1'b0, adr, '0, rsp, exp_rd);
      expected.ack = 1'b1;
      expected.dat = exp_rd;
      compare_rsp($sformatf("o_wb read at %h", adr), expected, rsp);
   endtask

   // ************************************************************
   // tests
   // ************************************************************

   task automatic test_reset();
      wb_rsp_t rsp;
      check_outputs();
      compare_word("o_bot_config", '0, gpio_word_t'(o_bot_config));
      for (int b = 0; b < 3; b++) begin
         do_read(reg_addr(b, `REG_OUT_OFS), rsp);
         do_read(reg_addr(b, `REG_OE_OFS), rsp);
      end
   endtask

   task automatic test_board();
      wb_rsp_t rsp;
      for (int n = 0; n < N_BOARD; n++) begin
         do_write(reg_addr(0, `REG_OUT_OFS), rand_bits(32));
         do_write(reg_addr(0, `REG_OE_OFS), rand_bits(32));
         do_read(reg_addr(0, `REG_OUT_OFS), rsp);
         do_read(reg_addr(0, `REG_OE_OFS), rsp);
         // pins change a full cycle before the read is issued
         @(posedge clk);
         #1;
         i_gpio = rand_bits(32);
         do_read(reg_addr(0, `REG_IN_OFS), rsp);
      end
   endtask

   task automatic test_robot();
      wb_rsp_t rsp;
      for (int n = 0; n < N_ROBOT; n++) begin
         do_write(reg_addr(2, `REG_OUT_OFS), rand_bits(32));
         @(posedge clk);
         #1;
         i_bot_info = rand_bits(32);
         do_read(reg_addr(2, `REG_IN_OFS), rsp);
      end
   endtask

   task automatic read_levels(input button_t lvl_btn, input switch_t lvl_sw);
      wb_rsp_t rsp;
      do_read(reg_addr(1, `REG_IN_OFS), rsp);
      compare_button("button in register", lvl_btn, button_t'(rsp.dat[BTN_W-1:0]));
      compare_word("o_bot_config", gpio_word_t'(lvl_sw[`BOT_CONFIG_SW]),
                   gpio_word_t'(o_bot_config));
   endtask

   // back to back reads of the button in register while the debouncer settles,
   // each one checked against the debounce model
   task automatic poll_buttons(input int cycles);
      wb_rsp_t rsp;
      for (int c = 0; c < cycles; c += ACC) begin
         do_read(reg_addr(1, `REG_IN_OFS), rsp);
      end
   endtask

   // a short pulse away from the level, then a new level held long enough
   task automatic test_debounce();
      button_t     lvl_btn;
      switch_t     lvl_sw;
      logic [31:0] r;
      int          len;
      lvl_btn = i_buttons;
      lvl_sw  = i_switches;
      for (int n = 0; n < N_DB; n++) begin
         r   = rand_bits(3);
         len = 1 + int'(r[2:0]) % (`DB_CYCLES - 1);
         @(posedge clk);
         #1;
         r          = rand_bits(BTN_W);
         i_buttons  = button_t'(r[BTN_W-1:0]);
         r          = rand_bits(16);
         i_switches = switch_t'(r[15:0]);
         i_switches[`BOT_CONFIG_SW] = ~lvl_sw[`BOT_CONFIG_SW];
         repeat (len) @(posedge clk);
         #1;
         i_buttons  = lvl_btn;
         i_switches = lvl_sw;
         poll_buttons(SETTLE);
         read_levels(lvl_btn, lvl_sw);
         // switch 15 toggles every round so o_bot_config keeps moving
         r       = rand_bits(BTN_W);
         lvl_btn = button_t'(r[BTN_W-1:0]);
         r       = rand_bits(16);
         r[`BOT_CONFIG_SW] = ~lvl_sw[`BOT_CONFIG_SW];
         lvl_sw  = switch_t'(r[15:0]);
         @(posedge clk);
         #1;
         i_buttons  = lvl_btn;
         i_switches = lvl_sw;
         poll_buttons(SETTLE);
         read_levels(lvl_btn, lvl_sw);
      end
   endtask

   task automatic test_unmapped();
      wb_rsp_t                   rsp;
      logic [31:0]               r;
      logic [`PERIPH_ADDR_W-1:0] adr;
      int                        w;
      for (int n = 0; n < N_UNMAP; n++) begin
         // top quarter of the map
         r   = rand_bits(4);
         adr = {2'b11, r[3:0], 2'b00};
         do_write(adr, rand_bits(32));
         do_read(adr, rsp);
         // holes above the enable register inside a real bank
         r   = rand_bits(8);
         w   = 3 + int'(r[7:4]) % 13;
         adr = reg_addr(int'(r[1:0]) % 3, 6'(w << 2));
         do_write(adr, rand_bits(32));
         do_read(adr, rsp);
      end
   endtask

   task automatic test_random();
      wb_rsp_t     rsp;
      logic [31:0] r;
      for (int n = 0; n < N_RAND; n++) begin
         r = rand_bits(7);
         if (r[6]) begin
            do_write({r[5:0], 2'b00}, rand_bits(32));
         end else begin
            do_read({r[5:0], 2'b00}, rsp);
         end
      end
   endtask

   initial begin
      i_arst_n   = 1'b0;
      i_wb       = '0;
      i_gpio     = '0;
      i_buttons  = '0;
      i_switches = '0;
      i_bot_info = '0;
      lfsr_q     = 16'd38;
      checks     = 0;
      value_errs = 0;
      bus_errs   = 0;
      for (int b = 0; b < 3; b++) begin
         exp_out[b] = '0;
         exp_oe[b]  = '0;
      end
      repeat (10) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      fork
         watch_config();
      join_none
      test_reset();
      test_board();
      test_robot();
      test_debounce();
      test_unmapped();
      test_random();
      print_counts();
      if (value_errs == 0 && bus_errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
